/* lsu_pkg.sv */
package lsu_pkg;

    // data and address width
    localparam int XLEN = 32;

    // access size code
    localparam int SIZE_W = 2;
    localparam logic [SIZE_W-1:0] SZ_BYTE = 2'd0;
    localparam logic [SIZE_W-1:0] SZ_HALF = 2'd1;
    localparam logic [SIZE_W-1:0] SZ_WORD = 2'd2;

    // memory operation from the execute stage
    typedef enum logic [3:0] {
        NONE,
        LB,
        LBU,
        LH,
        LHU,
        LW,
        SB,
        SH,
        SW,
        LR_W,
        SC_W,
        AMO
    } mem_op_t;

    // amo function, only meaningful with AMO
    typedef enum logic [3:0] {
        SWAP,
        ADD,
        XOR,
        AND,
        OR,
        MIN,
        MAX,
        MINU,
        MAXU
    } amo_op_t;

    // clint register map
    localparam logic [XLEN-1:0] MTIME_LO_ADDR    = 32'h0200_BFF8;
    localparam logic [XLEN-1:0] MTIME_HI_ADDR    = 32'h0200_BFFC;
    localparam logic [XLEN-1:0] MTIMECMP_LO_ADDR = 32'h0200_4000;
    localparam logic [XLEN-1:0] MTIMECMP_HI_ADDR = 32'h0200_4004;

    // atomic engine states
    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        CALC,
        STORE
    } amo_state_t;

endpackage

/* lsu_decode.sv */
module lsu_decode (
    input  lsu_pkg::mem_op_t               mem_op_i,
    input  logic [lsu_pkg::XLEN-1:0]       addr_i,
    output logic                           is_load_o,
    output logic                           is_store_o,
    output logic                           is_atomic_o,
    output logic                           load_signed_o,
    output logic [lsu_pkg::SIZE_W-1:0]     size_o,
    output logic                           clint_hit_o,
    output logic                           misaligned_o
);

    // operation classes
    assign is_load_o = mem_op_i inside {lsu_pkg::LB, lsu_pkg::LBU, lsu_pkg::LH,
                                        lsu_pkg::LHU, lsu_pkg::LW};
    assign is_store_o = mem_op_i inside {lsu_pkg::SB, lsu_pkg::SH, lsu_pkg::SW};
    assign is_atomic_o = mem_op_i inside {lsu_pkg::LR_W, lsu_pkg::SC_W, lsu_pkg::AMO};

    // lw needs no extension, only the sub-word loads
    assign load_signed_o = (mem_op_i == lsu_pkg::LB) || (mem_op_i == lsu_pkg::LH);

    // width of the access
    always_comb begin
        case (mem_op_i)
            lsu_pkg::LB, lsu_pkg::LBU, lsu_pkg::SB: begin
                size_o = lsu_pkg::SZ_BYTE;
            end
            lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH: begin
                size_o = lsu_pkg::SZ_HALF;
            end
            // words and all atomics
            default: begin
                size_o = lsu_pkg::SZ_WORD;
            end
        endcase
    end

    // timer register match, address only
    assign clint_hit_o = (addr_i == lsu_pkg::MTIME_LO_ADDR) ||
                         (addr_i == lsu_pkg::MTIME_HI_ADDR) ||
                         (addr_i == lsu_pkg::MTIMECMP_LO_ADDR) ||
                         (addr_i == lsu_pkg::MTIMECMP_HI_ADDR);

    // atomics must be word aligned
    assign misaligned_o = is_atomic_o && (addr_i[1:0] != 2'b00);

endmodule

/* lsu_align.sv */
module lsu_align (
    input  logic [lsu_pkg::SIZE_W-1:0] size_i,
    input  logic                       load_signed_i,
    input  logic [1:0]                 addr_lo_i,
    input  logic [lsu_pkg::XLEN-1:0]   store_data_i,
    input  logic [lsu_pkg::XLEN-1:0]   raw_rdata_i,
    output logic [3:0]                 byte_mask_o,
    output logic [lsu_pkg::XLEN-1:0]   lane_wdata_o,
    output logic [lsu_pkg::XLEN-1:0]   load_data_o
);

    logic [3:0]               base_mask;
    logic [4:0]               lane_shift;
    logic [lsu_pkg::XLEN-1:0] lane_rdata;

    // byte offset in bits
    assign lane_shift = {addr_lo_i, 3'b000};

    // mask at lane 0 before shifting
    always_comb begin
        case (size_i)
            lsu_pkg::SZ_BYTE: base_mask = 4'b0001;
            lsu_pkg::SZ_HALF: base_mask = 4'b0011;
            default:          base_mask = 4'b1111;
        endcase
    end

    assign byte_mask_o = base_mask << addr_lo_i;

    // store data moved up to the addressed lane
    assign lane_wdata_o = store_data_i << lane_shift;

    // addressed bytes moved down to lane 0
    assign lane_rdata = raw_rdata_i >> lane_shift;

    // sign or zero fill above the accessed bytes
    always_comb begin
        case (size_i)
            lsu_pkg::SZ_BYTE: begin
                load_data_o = {{24{load_signed_i & lane_rdata[7]}}, lane_rdata[7:0]};
            end
            lsu_pkg::SZ_HALF: begin
                load_data_o = {{16{load_signed_i & lane_rdata[15]}}, lane_rdata[15:0]};
            end
            default: begin
                load_data_o = lane_rdata;
            end
        endcase
    end

endmodule

/* amo_alu.sv */
module amo_alu (
    input  lsu_pkg::amo_op_t         amo_op_i,
    input  logic [lsu_pkg::XLEN-1:0] mem_val_i,
    input  logic [lsu_pkg::XLEN-1:0] rs2_val_i,
    output logic [lsu_pkg::XLEN-1:0] new_val_o
);

    logic ult;
    logic slt;

    // memory value below rs2, unsigned
    assign ult = mem_val_i < rs2_val_i;

    // signed: differing signs decide, else same as unsigned
    assign slt = (mem_val_i[31] != rs2_val_i[31]) ? mem_val_i[31] : ult;

    always_comb begin
        case (amo_op_i)
            lsu_pkg::SWAP: new_val_o = rs2_val_i;
            lsu_pkg::ADD:  new_val_o = mem_val_i + rs2_val_i;
            lsu_pkg::XOR:  new_val_o = mem_val_i ^ rs2_val_i;
            lsu_pkg::AND:  new_val_o = mem_val_i & rs2_val_i;
            lsu_pkg::OR:   new_val_o = mem_val_i | rs2_val_i;
            lsu_pkg::MIN:  new_val_o = slt ? mem_val_i : rs2_val_i;
            lsu_pkg::MAX:  new_val_o = slt ? rs2_val_i : mem_val_i;
            lsu_pkg::MINU: new_val_o = ult ? mem_val_i : rs2_val_i;
            lsu_pkg::MAXU: new_val_o = ult ? rs2_val_i : mem_val_i;
            // unknown function behaves as swap
            default:       new_val_o = rs2_val_i;
        endcase
    end

endmodule

/* lsu_amo_engine.sv */
module lsu_amo_engine (
    input  logic                     clk,
    input  logic                     rst,
    input  lsu_pkg::mem_op_t         mem_op_i,
    input  lsu_pkg::amo_op_t         amo_op_i,
    input  logic [lsu_pkg::XLEN-1:0] addr_i,
    input  logic [lsu_pkg::XLEN-1:0] rs2_i,
    input  logic                     start_i,
    input  logic                     plain_store_i,
    input  logic                     mem_ready_i,
    input  logic [lsu_pkg::XLEN-1:0] mem_rdata_i,
    output logic                     rd_req_o,
    output logic                     wr_req_o,
    output logic                     busy_o,
    output logic                     done_o,
    output logic [lsu_pkg::XLEN-1:0] store_val_o,
    output logic [lsu_pkg::XLEN-1:0] result_o
);

    lsu_pkg::amo_state_t      state;
    logic [lsu_pkg::XLEN-1:0] loaded_q;
    logic [lsu_pkg::XLEN-1:0] new_val;
    logic [lsu_pkg::XLEN-1:0] new_val_q;
    logic [lsu_pkg::XLEN-1:0] res_addr_q;
    logic                     res_valid_q;
    logic                     launch;
    logic                     is_sc;
    logic                     sc_ok;

    amo_alu i_amo_alu (
        .amo_op_i  (amo_op_i),
        .mem_val_i (loaded_q),
        .rs2_val_i (rs2_i),
        .new_val_o (new_val)
    );

    // op is still presented in the done cycle, do not restart it
    assign launch = start_i && !done_o && (state == lsu_pkg::IDLE);
    assign is_sc = (mem_op_i == lsu_pkg::SC_W);
    assign sc_ok = res_valid_q && (res_addr_q == addr_i);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= lsu_pkg::IDLE;
            done_o <= 1'b0;
            res_valid_q <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state)
                lsu_pkg::IDLE: begin
                    if (launch && is_sc) begin
                        // any sc drops the reservation
                        res_valid_q <= 1'b0;
                        if (sc_ok) begin
                            state <= lsu_pkg::STORE;
                        end else begin
                            done_o <= 1'b1;
                        end
                    end else if (launch) begin
                        // lr and amo both reserve
                        res_valid_q <= 1'b1;
                        state <= lsu_pkg::LOAD;
                    end
                end
                lsu_pkg::LOAD: begin
                    if (mem_ready_i && (mem_op_i == lsu_pkg::LR_W)) begin
                        state <= lsu_pkg::IDLE;
                        done_o <= 1'b1;
                    end else if (mem_ready_i) begin
                        state <= lsu_pkg::CALC;
                    end
                end
                lsu_pkg::CALC: begin
                    state <= lsu_pkg::STORE;
                end
                lsu_pkg::STORE: begin
                    if (mem_ready_i) begin
                        state <= lsu_pkg::IDLE;
                        done_o <= 1'b1;
                        res_valid_q <= 1'b0;
                    end
                end
                default: begin
                    state <= lsu_pkg::IDLE;
                end
            endcase
            // a plain store kills the reservation
            if (plain_store_i) begin
                res_valid_q <= 1'b0;
            end
        end
    end

    // data path
    always_ff @(posedge clk) begin
        if (launch && !is_sc) begin
            res_addr_q <= addr_i;
        end
        if ((state == lsu_pkg::LOAD) && mem_ready_i) begin
            loaded_q <= mem_rdata_i;
            // old value is the result for lr and amo
            result_o <= mem_rdata_i;
        end
        if (state == lsu_pkg::CALC) begin
            new_val_q <= new_val;
        end
        // sc codes: 0 stored, 1 failed
        if (launch && is_sc && !sc_ok) begin
            result_o <= 32'd1;
        end
        if ((state == lsu_pkg::STORE) && mem_ready_i && is_sc) begin
            result_o <= 32'd0;
        end
    end

    assign rd_req_o = (state == lsu_pkg::LOAD);
    assign wr_req_o = (state == lsu_pkg::STORE);
    assign busy_o = (state != lsu_pkg::IDLE) || start_i;

    // sc and plain stores write rs2
    assign store_val_o = (mem_op_i == lsu_pkg::AMO) ? new_val_q : rs2_i;

    // done only on the return to idle, and only for one cycle
    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        done_o |-> (state == lsu_pkg::IDLE) ##1 !done_o);

    a_req_excl: assert property (@(posedge clk) disable iff (rst)
        !(rd_req_o && wr_req_o));

endmodule

/* lsu_mem_ctrl.sv */
module lsu_mem_ctrl (
    input  logic                     is_load_i,
    input  logic                     is_store_i,
    input  logic                     is_atomic_i,
    input  logic                     clint_hit_i,
    input  logic                     eng_rd_req_i,
    input  logic                     eng_wr_req_i,
    input  logic                     eng_busy_i,
    input  logic                     eng_done_i,
    input  logic                     mem_ready_i,
    input  logic [lsu_pkg::XLEN-1:0] load_data_i,
    input  logic [lsu_pkg::XLEN-1:0] eng_result_i,
    input  logic [lsu_pkg::XLEN-1:0] addr_i,
    input  logic [lsu_pkg::XLEN-1:0] mem_rdata_i,
    input  logic [lsu_pkg::XLEN-1:0] clint_rdata_i,
    output logic                     mem_req_o,
    output logic                     mem_we_o,
    output logic                     clint_sel_o,
    output logic                     clint_we_o,
    output logic                     stall_o,
    output logic [lsu_pkg::XLEN-1:0] raw_rdata_o,
    output logic [lsu_pkg::XLEN-1:0] data_o
);

    logic plain_any;
    logic plain_mem;

    assign plain_any = is_load_i || is_store_i;

    // timer takes plain accesses only
    assign clint_sel_o = plain_any && clint_hit_i;
    assign clint_we_o = clint_sel_o && is_store_i;
    assign plain_mem = plain_any && !clint_hit_i;

    // request drops in the ready cycle so the access completes once
    assign mem_req_o = (plain_mem || eng_rd_req_i || eng_wr_req_i) && !mem_ready_i;
    assign mem_we_o = (plain_mem && is_store_i) || eng_wr_req_i;

    // timer data is read in the presentation cycle
    assign raw_rdata_o = clint_sel_o ? clint_rdata_i : mem_rdata_i;

    // plain stall ends with ready, atomic stall ends with done
    assign stall_o = (plain_mem && !mem_ready_i) || (eng_busy_i && !eng_done_i);

    // write-back value
    always_comb begin
        if (is_atomic_i) begin
            data_o = eng_result_i;
        end else if (is_load_i) begin
            data_o = load_data_i;
        end else begin
            // stores and non-memory ops pass the alu result
            data_o = addr_i;
        end
    end

    // engine requests only come with atomics, which never reach the timer
    always_comb begin
        a_port_excl: assert #0 (!(clint_sel_o && mem_req_o));
    end

endmodule

/* lsu_top.sv */
module lsu_top (
    input  logic                     clk,
    input  logic                     rst,
    input  lsu_pkg::mem_op_t         mem_op_i,
    input  lsu_pkg::amo_op_t         amo_op_i,
    input  logic [lsu_pkg::XLEN-1:0] addr_i,
    input  logic [lsu_pkg::XLEN-1:0] wdata_i,
    input  logic                     mem_ready_i,
    input  logic [lsu_pkg::XLEN-1:0] mem_rdata_i,
    input  logic [lsu_pkg::XLEN-1:0] clint_rdata_i,
    output logic                     mem_req_o,
    output logic                     mem_we_o,
    output logic [lsu_pkg::XLEN-1:0] mem_addr_o,
    output logic [3:0]               mem_mask_o,
    output logic [lsu_pkg::XLEN-1:0] mem_wdata_o,
    output logic                     clint_sel_o,
    output logic                     clint_we_o,
    output logic [lsu_pkg::XLEN-1:0] clint_wdata_o,
    output logic [lsu_pkg::XLEN-1:0] data_o,
    output logic                     stall_o,
    output logic                     trap_misaligned_o
);

    logic                       is_load;
    logic                       is_store;
    logic                       is_atomic;
    logic                       load_signed;
    logic [lsu_pkg::SIZE_W-1:0] size;
    logic                       clint_hit;
    logic                       misaligned;
    logic [lsu_pkg::XLEN-1:0]   lane_wdata;
    logic [lsu_pkg::XLEN-1:0]   load_data;
    logic [lsu_pkg::XLEN-1:0]   raw_rdata;
    logic                       eng_rd_req;
    logic                       eng_wr_req;
    logic                       eng_busy;
    logic                       eng_done;
    logic [lsu_pkg::XLEN-1:0]   store_val;
    logic [lsu_pkg::XLEN-1:0]   eng_result;

    lsu_decode i_lsu_decode (
        .mem_op_i      (mem_op_i),
        .addr_i        (addr_i),
        .is_load_o     (is_load),
        .is_store_o    (is_store),
        .is_atomic_o   (is_atomic),
        .load_signed_o (load_signed),
        .size_o        (size),
        .clint_hit_o   (clint_hit),
        .misaligned_o  (misaligned)
    );

    // store data comes from the engine, rs2 or the amo value
    lsu_align i_lsu_align (
        .size_i        (size),
        .load_signed_i (load_signed),
        .addr_lo_i     (addr_i[1:0]),
        .store_data_i  (store_val),
        .raw_rdata_i   (raw_rdata),
        .byte_mask_o   (mem_mask_o),
        .lane_wdata_o  (lane_wdata),
        .load_data_o   (load_data)
    );

    lsu_amo_engine i_lsu_amo_engine (
        .clk           (clk),
        .rst           (rst),
        .mem_op_i      (mem_op_i),
        .amo_op_i      (amo_op_i),
        .addr_i        (addr_i),
        .rs2_i         (wdata_i),
        .start_i       (is_atomic && !misaligned),
        .plain_store_i (is_store),
        .mem_ready_i   (mem_ready_i),
        .mem_rdata_i   (mem_rdata_i),
        .rd_req_o      (eng_rd_req),
        .wr_req_o      (eng_wr_req),
        .busy_o        (eng_busy),
        .done_o        (eng_done),
        .store_val_o   (store_val),
        .result_o      (eng_result)
    );

    lsu_mem_ctrl i_lsu_mem_ctrl (
        .is_load_i     (is_load),
        .is_store_i    (is_store),
        .is_atomic_i   (is_atomic),
        .clint_hit_i   (clint_hit),
        .eng_rd_req_i  (eng_rd_req),
        .eng_wr_req_i  (eng_wr_req),
        .eng_busy_i    (eng_busy),
        .eng_done_i    (eng_done),
        .mem_ready_i   (mem_ready_i),
        .load_data_i   (load_data),
        .eng_result_i  (eng_result),
        .addr_i        (addr_i),
        .mem_rdata_i   (mem_rdata_i),
        .clint_rdata_i (clint_rdata_i),
        .mem_req_o     (mem_req_o),
        .mem_we_o      (mem_we_o),
        .clint_sel_o   (clint_sel_o),
        .clint_we_o    (clint_we_o),
        .stall_o       (stall_o),
        .raw_rdata_o   (raw_rdata),
        .data_o        (data_o)
    );

    // address is always the alu result
    assign mem_addr_o = addr_i;
    assign mem_wdata_o = lane_wdata;
    assign clint_wdata_o = lane_wdata;
    assign trap_misaligned_o = misaligned;

endmodule

/* tb_clk_gen.sv */
module tb_clk_gen (
    output logic clk_o,
    output logic rst_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // 20 ns period
    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;
    end

    // reset held for 5 cycles, released on a falling edge
    initial begin
        rst_o = 1'b1;
        repeat (5) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule

/* tb_lsu.sv */
module tb_lsu;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT = 50;

    logic clk, rst;
    lsu_pkg::mem_op_t mem_op;
    lsu_pkg::amo_op_t amo_op;
    logic [31:0] addr, wdata, mem_rdata, clint_rdata;
    logic mem_ready, req_seen;
    logic mem_req_o, mem_we_o, clint_sel_o, clint_we_o, stall_o, trap_misaligned_o;
    logic [31:0] mem_addr_o, mem_wdata_o, clint_wdata_o, data_o;
    logic [3:0] mem_mask_o;
    logic [31:0] mem [64];
    logic [31:0] shadow [64];
    int seed = 7;
    int delay = -1;
    string test_name = "reset";
    logic chk_store, chk_load, chk_clint, chk_clint_ld, chk_atomic, chk_mem, chk_trap, chk_idle;
    logic [31:0] exp_data, exp_wdata;
    logic [3:0] exp_mask;
    int chk_idx;

    tb_clk_gen i_tb_clk_gen (.clk_o(clk), .rst_o(rst));

    lsu_top i_lsu_top (
        .clk(clk), .rst(rst), .mem_op_i(mem_op), .amo_op_i(amo_op), .addr_i(addr),
        .wdata_i(wdata), .mem_ready_i(mem_ready), .mem_rdata_i(mem_rdata),
        .clint_rdata_i(clint_rdata), .mem_req_o(mem_req_o), .mem_we_o(mem_we_o),
        .mem_addr_o(mem_addr_o), .mem_mask_o(mem_mask_o), .mem_wdata_o(mem_wdata_o),
        .clint_sel_o(clint_sel_o), .clint_we_o(clint_we_o), .clint_wdata_o(clint_wdata_o),
        .data_o(data_o), .stall_o(stall_o), .trap_misaligned_o(trap_misaligned_o)
    );

    task automatic stop_with_failure(string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(string what, logic [31:0] expv, logic [31:0] actv);
        $display("CHECK FAILED %s (%s): expected %h, actual %h", test_name, what, expv, actv);
        stop_with_failure("value mismatch");
    endtask

    // memory model sees the request at the rising edge and answers on a falling edge
    always @(posedge clk) req_seen <= mem_req_o;

    always @(negedge clk) begin
        if (mem_ready) begin
            mem_ready <= 1'b0;
        end else if (req_seen && !rst) begin
            if (delay < 0) delay = $random(seed) & 3;
            if (delay == 0) begin
                mem_ready <= 1'b1;
                mem_rdata <= mem[mem_addr_o[7:2]];
                delay = -1;
            end else begin
                delay = delay - 1;
            end
        end
    end

    // masked write in the completion cycle
    always @(posedge clk) begin
        if (mem_ready && mem_we_o) begin
            for (int b = 0; b < 4; b++) begin
                if (mem_mask_o[b]) mem[mem_addr_o[7:2]][8*b +: 8] <= mem_wdata_o[8*b +: 8];
            end
        end
    end

    // checks
    a_store_mask: assert property (@(posedge clk) disable iff (rst)
        (chk_store && mem_req_o) |-> (mem_mask_o == exp_mask))
        else report_mismatch("mask", {28'd0, exp_mask}, {28'd0, $sampled(mem_mask_o)});
    a_store_data: assert property (@(posedge clk) disable iff (rst)
        (chk_store && mem_req_o) |-> (mem_wdata_o == exp_wdata))
        else report_mismatch("wdata", exp_wdata, $sampled(mem_wdata_o));
    a_load_data: assert property (@(posedge clk) disable iff (rst)
        (chk_load && mem_ready) |-> (data_o == exp_data))
        else report_mismatch("load data", exp_data, $sampled(data_o));
    a_clint_port: assert property (@(posedge clk) disable iff (rst)
        chk_clint |-> (clint_sel_o && !mem_req_o && !stall_o))
        else stop_with_failure("timer access did not select the timer port alone");
    a_clint_we: assert property (@(posedge clk) disable iff (rst)
        chk_clint |-> (clint_we_o == !chk_clint_ld))
        else report_mismatch("timer write enable", {31'd0, !chk_clint_ld},
                             {31'd0, $sampled(clint_we_o)});
    a_clint_wdata: assert property (@(posedge clk) disable iff (rst)
        (chk_clint && !chk_clint_ld) |-> (clint_wdata_o == exp_wdata))
        else report_mismatch("timer wdata", exp_wdata, $sampled(clint_wdata_o));
    a_clint_data: assert property (@(posedge clk) disable iff (rst)
        chk_clint_ld |-> (data_o == exp_data))
        else report_mismatch("timer data", exp_data, $sampled(data_o));
    a_atomic_result: assert property (@(posedge clk) disable iff (rst)
        (chk_atomic && !stall_o) |-> (data_o == exp_data))
        else report_mismatch("atomic result", exp_data, $sampled(data_o));
    a_mem_word: assert property (@(posedge clk) disable iff (rst)
        chk_mem |-> (mem[chk_idx] == shadow[chk_idx]))
        else report_mismatch("memory word", shadow[chk_idx], mem[chk_idx]);
    a_trap: assert property (@(posedge clk) disable iff (rst)
        chk_trap |-> (trap_misaligned_o && !mem_req_o && !stall_o))
        else stop_with_failure("misaligned atomic gave no trap or was started");
    a_idle: assert property (@(posedge clk)
        chk_idle |-> (!stall_o && !mem_req_o))
        else stop_with_failure("stall or request high while idle");

    // expected load and amo values
    function automatic logic [31:0] extend(lsu_pkg::mem_op_t op, logic [31:0] w, int off);
        logic [31:0] s;
        s = w >> (8 * off);
        case (op)
            lsu_pkg::LB:  return {{24{s[7]}}, s[7:0]};
            lsu_pkg::LBU: return {24'd0, s[7:0]};
            lsu_pkg::LH:  return {{16{s[15]}}, s[15:0]};
            lsu_pkg::LHU: return {16'd0, s[15:0]};
            default:      return w;
        endcase
    endfunction

    function automatic logic [31:0] amo_rule(lsu_pkg::amo_op_t f, logic [31:0] m,
                                             logic [31:0] r);
        case (f)
            lsu_pkg::ADD:  return m + r;
            lsu_pkg::XOR:  return m ^ r;
            lsu_pkg::AND:  return m & r;
            lsu_pkg::OR:   return m | r;
            lsu_pkg::MIN:  return ($signed(m) < $signed(r)) ? m : r;
            lsu_pkg::MAX:  return ($signed(m) > $signed(r)) ? m : r;
            lsu_pkg::MINU: return (m < r) ? m : r;
            lsu_pkg::MAXU: return (m > r) ? m : r;
            default:       return r;
        endcase
    endfunction

    // new inputs and all checks off on the falling edge
    task automatic present(lsu_pkg::mem_op_t op, lsu_pkg::amo_op_t f, logic [31:0] a,
                           logic [31:0] d);
        @(negedge clk);
        {chk_store, chk_load, chk_clint, chk_clint_ld} = 4'b0;
        {chk_atomic, chk_mem, chk_trap, chk_idle} = 4'b0;
        mem_op = op;
        amo_op = f;
        addr = a;
        wdata = d;
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        @(posedge clk);
        while (!mem_ready) begin
            n++;
            if (n > TIMEOUT) stop_with_failure("no ready from the memory model");
            @(posedge clk);
        end
    endtask

    // done cycle is the first one with stall low
    task automatic wait_atomic();
        int n;
        n = 0;
        @(negedge clk);
        while (stall_o) begin
            n++;
            if (n > TIMEOUT) stop_with_failure("atomic never finished");
            @(negedge clk);
        end
    endtask

    task automatic check_word(int idx);
        present(lsu_pkg::NONE, lsu_pkg::SWAP, 32'd0, 32'd0);
        chk_idx = idx;
        chk_mem = 1'b1;
        @(posedge clk);
    endtask

    task automatic plain_store(lsu_pkg::mem_op_t op, int idx, int off, logic [31:0] d);
        present(op, lsu_pkg::SWAP, idx * 4 + off, d);
        exp_mask = ((op == lsu_pkg::SB) ? 4'b0001 : (op == lsu_pkg::SH) ? 4'b0011 : 4'b1111)
                   << off;
        exp_wdata = d << (8 * off);
        for (int b = 0; b < 4; b++) begin
            if (exp_mask[b]) shadow[idx][8*b +: 8] = exp_wdata[8*b +: 8];
        end
        chk_store = 1'b1;
        wait_ready();
        check_word(idx);
    endtask

    task automatic run_atomic(lsu_pkg::mem_op_t op, lsu_pkg::amo_op_t f, int idx,
                              logic [31:0] d, logic [31:0] expv);
        present(op, f, idx * 4, d);
        exp_data = expv;
        chk_atomic = 1'b1;
        wait_atomic();
    endtask

    initial begin
        lsu_pkg::mem_op_t lop;
        lsu_pkg::amo_op_t f;
        logic [31:0] d, old;
        int n;
        mem_op = lsu_pkg::NONE;
        amo_op = lsu_pkg::SWAP;
        {addr, wdata, clint_rdata} = '0;
        mem_rdata <= '0;
        mem_ready <= 1'b0;
        {chk_store, chk_load, chk_clint, chk_clint_ld} = 4'b0;
        {chk_atomic, chk_mem, chk_trap, chk_idle} = 4'b0;
        {exp_data, exp_wdata, exp_mask, chk_idx} = '0;
        // fill with high bytes set and a different value per word
        for (int i = 0; i < 64; i++) begin
            shadow[i] = 32'h80A0_C0E0 ^ (i * 32'h0103_0507);
            mem[i] <= shadow[i];
        end
        n = 0;
        while (rst !== 1'b0) begin
            n++;
            if (n > TIMEOUT) stop_with_failure("reset never released");
            @(negedge clk);
        end
        test_name = "idle after reset";
        chk_idle = 1'b1;
        repeat (3) @(posedge clk);

        for (int off = 0; off < 4; off++) begin
            test_name = $sformatf("sb offset %0d", off);
            plain_store(lsu_pkg::SB, 4, off, $random(seed));
        end
        for (int off = 0; off < 3; off++) begin
            test_name = $sformatf("sh offset %0d", off);
            plain_store(lsu_pkg::SH, 5 + off, off, $random(seed));
        end

        for (int k = 1; k <= 5; k++) begin
            lop = lsu_pkg::mem_op_t'(k);
            for (int off = 0; off < 4; off++) begin
                if (k >= 3 && off == 3) continue;
                if (k == 5 && off != 0) continue;
                test_name = $sformatf("%s offset %0d", lop.name(), off);
                present(lop, lsu_pkg::SWAP, 40 + off, 32'd0);
                exp_data = extend(lop, shadow[10], off);
                chk_load = 1'b1;
                wait_ready();
            end
        end

        for (int t = 0; t < 8; t++) begin
            d = (t % 4 == 0) ? lsu_pkg::MTIME_LO_ADDR : (t % 4 == 1) ? lsu_pkg::MTIME_HI_ADDR :
                (t % 4 == 2) ? lsu_pkg::MTIMECMP_LO_ADDR : lsu_pkg::MTIMECMP_HI_ADDR;
            test_name = $sformatf("timer %h %s", d, (t < 4) ? "load" : "store");
            exp_wdata = $random(seed);
            present((t < 4) ? lsu_pkg::LW : lsu_pkg::SW, lsu_pkg::SWAP, d, exp_wdata);
            clint_rdata = $random(seed);
            exp_data = clint_rdata;
            chk_clint = 1'b1;
            chk_clint_ld = (t < 4);
            @(posedge clk);
        end

        for (int k = 0; k < 9; k++) begin
            f = lsu_pkg::amo_op_t'(k);
            test_name = $sformatf("amo %s", f.name());
            old = $random(seed);
            d = $random(seed);
            // min and max operands of opposite sign so signed and unsigned orders differ
            if (k >= 5) begin
                old[31] = k[0];
                d[31] = !k[0];
            end
            mem[20 + k] <= old;
            shadow[20 + k] = amo_rule(f, old, d);
            run_atomic(lsu_pkg::AMO, f, 20 + k, d, old);
            check_word(20 + k);
        end

        test_name = "lr then sc";
        run_atomic(lsu_pkg::LR_W, lsu_pkg::SWAP, 40, 32'd0, shadow[40]);
        d = $random(seed);
        shadow[40] = d;
        run_atomic(lsu_pkg::SC_W, lsu_pkg::SWAP, 40, d, 32'd0);
        check_word(40);
        test_name = "sc after plain store";
        run_atomic(lsu_pkg::LR_W, lsu_pkg::SWAP, 41, 32'd0, shadow[41]);
        plain_store(lsu_pkg::SW, 42, 0, $random(seed));
        run_atomic(lsu_pkg::SC_W, lsu_pkg::SWAP, 41, $random(seed), 32'd1);
        check_word(41);
        test_name = "sc to other address";
        run_atomic(lsu_pkg::LR_W, lsu_pkg::SWAP, 43, 32'd0, shadow[43]);
        run_atomic(lsu_pkg::SC_W, lsu_pkg::SWAP, 44, $random(seed), 32'd1);
        check_word(44);

        test_name = "misaligned atomic";
        present(lsu_pkg::AMO, lsu_pkg::ADD, 32'h0000_0091, 32'd5);
        chk_trap = 1'b1;
        repeat (3) @(posedge clk);
        present(lsu_pkg::NONE, lsu_pkg::SWAP, 32'd0, 32'd0);
        chk_idle = 1'b1;
        repeat (2) @(posedge clk);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* sources.f */
lsu_pkg.sv
lsu_decode.sv
lsu_align.sv
amo_alu.sv
lsu_amo_engine.sv
lsu_mem_ctrl.sv
lsu_top.sv
tb_clk_gen.sv
tb_lsu.sv

/* run.sh */
#!/bin/sh
# build with Verilator and run the testbench; pass only if the pass line appears
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_lsu \
    -f sources.f -o sim_lsu &&
./obj_dir/sim_lsu | tee /dev/stderr | grep -q -F "*** PASSED ***" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
